// ==== flist.f ====
src/cache_pkg.sv
src/cache_tag_array.sv
src/cache_data_array.sv
src/cache_control.sv
src/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FLIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)

run: compile
	-./$(BINARY) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

    localparam int num_ops    = 400;
    localparam int max_cycles = num_ops * 40;       // a dirty miss needs well under 40 cycles

    logic             clk = 1'b0;
    logic             reset;
    logic             req_valid, req_ready, req_write;
    cache_pkg::addr_t req_addr;
    cache_pkg::word_t req_wdata;
    cache_pkg::mask_t req_mask;
    logic             resp_valid, resp_ready;
    cache_pkg::word_t resp_rdata;
    logic             mem_valid, mem_ready, mem_write, mem_rvalid;
    cache_pkg::addr_t mem_addr;
    cache_pkg::line_t mem_wdata, mem_rdata;

    cache_pkg::word_t shadow [512];                 // what the processor must see, 2 KiB of words
    cache_pkg::line_t mem_lines [64];               // backing store behind the cache
    logic [7:0]       res_valid;                    // sets that the model knows are filled
    logic [5:0]       res_line [8];                 // line number resident in each set
    logic [7:0]       res_dirty;                    // resident line was written since its fill
    int               cycle = 0;
    int               ops_done = 0;
    int               line_writes = 0;              // running totals kept by the memory model
    int               line_reads = 0;
    int               accept_cycle, writes_at_accept, reads_at_accept, exp_writes;
    cache_pkg::addr_t victim_addr, fill_addr;
    cache_pkg::word_t exp_word;
    logic             in_flight, exp_resident;

    cache_top #(.s_index(3)) u_cache_top (.*);

    always #20 clk = ~clk;                          // 40 ns period

    // ----------------------------------------------------------------------
    // reference model and failure handling
    // ----------------------------------------------------------------------

    function automatic cache_pkg::word_t fill_word(input int widx);
        return cache_pkg::word_t'(widx * 32'h9e37_79b9 + 32'h1234_5678); // every word differs
    endfunction

    function automatic cache_pkg::word_t apply_access(input int widx, input logic write,
                                                      input cache_pkg::word_t wdata,
                                                      input cache_pkg::mask_t mask);
        cache_pkg::word_t w;
        w = shadow[widx];
        for (int b = 0; b < 4; b++) begin
            if (write && mask[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];      // only enabled bytes move
            end
        end
        shadow[widx] = w;
        return w;                                   // read word, or the word after the write
    endfunction

    function automatic cache_pkg::line_t shadow_line(input int lidx);
        cache_pkg::line_t l;
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = shadow[lidx*8 + k];
        end
        return l;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    initial begin : stimulus
        int lidx;
        void'($urandom(32'h89a6));                  // one seed for the whole run
        reset     = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_wdata = '0;
        req_mask  = '0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        repeat (3) begin
            @(posedge clk);
            assert (req_ready && !resp_valid && !mem_valid)
                else flag_mismatch("idle outputs wrong after reset");
        end
        #2;
        for (int n = 0; n < num_ops; n++) begin
            lidx      = ($urandom % 4) * 8 + $urandom % 8; // four tags per set keep evicting
            req_addr  = cache_pkg::addr_t'(lidx * 32 + ($urandom % 8) * 4);
            req_write = ($urandom % 2) == 1;
            req_wdata = $urandom;
            req_mask  = cache_pkg::mask_t'($urandom % 15 + 1);
            req_valid = 1'b1;
            do @(posedge clk); while (!req_ready);  // fields held until the cache takes them
            #2 req_valid = 1'b0;
        end
        wait (ops_done == num_ops);
        @(posedge clk);
        if (u_cache_top.u_props.failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("a protocol assertion failed during the run");
            abort_run();
        end
    end

    initial begin : response_pacing
        resp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2 resp_ready = ($urandom % 4) != 0;    // back-pressure about one cycle in four
        end
    end

    // ----------------------------------------------------------------------
    // memory model
    // ----------------------------------------------------------------------

    initial begin : memory_model
        int   ready_wait;
        int   fill_wait;
        int   lidx;
        logic seen_valid;
        for (int i = 0; i < 64; i++) begin
            for (int k = 0; k < 8; k++) begin
                mem_lines[i][k*32 +: 32] = fill_word(i * 8 + k);
            end
        end
        mem_ready  = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        ready_wait = 0;
        fill_wait  = 0;
        lidx       = 0;
        forever begin
            @(posedge clk);
            seen_valid = mem_valid && !mem_ready;   // request still waiting for ready
            if (mem_valid && mem_ready) begin
                lidx = int'(mem_addr[10:5]);
                if (mem_write) begin
                    assert (mem_addr == victim_addr && mem_wdata == shadow_line(lidx))
                        else flag_mismatch($sformatf("bad write-back to %h", mem_addr));
                    mem_lines[lidx] = mem_wdata;
                    line_writes++;
                end else begin
                    assert (mem_addr == fill_addr)
                        else flag_mismatch($sformatf("fill read from %h, expected %h",
                                                     mem_addr, fill_addr));
                    fill_wait = 1 + $urandom % 4;   // data comes back 1 to 4 cycles later
                    line_reads++;
                end
                ready_wait = $urandom % 4;
            end
            #2;
            mem_rvalid = 1'b0;
            mem_ready  = 1'b0;
            if (fill_wait > 0) begin
                fill_wait--;
                if (fill_wait == 0) begin
                    mem_rvalid = 1'b1;              // single-cycle strobe with the whole line
                    mem_rdata  = mem_lines[lidx];
                end
            end
            if (seen_valid) begin
                if (ready_wait == 0) begin
                    mem_ready = 1'b1;
                end else begin
                    ready_wait--;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // comparing process
    // ----------------------------------------------------------------------

    always @(posedge clk) begin : compare
        int set;
        if (reset) begin
            res_valid = '0;
            res_dirty = '0;
            in_flight = 1'b0;
            for (int i = 0; i < 512; i++) begin
                shadow[i] = fill_word(i);           // same image as the memory model
            end
        end else begin
            if (in_flight) begin
                assert (!req_ready) else flag_mismatch("req_ready high before the response");
                if (exp_resident && cycle == accept_cycle + 1) begin
                    assert (resp_valid) else flag_mismatch("resident line did not answer at once");
                end
                if (resp_valid && resp_ready) begin
                    assert (resp_rdata == exp_word)
                        else flag_mismatch($sformatf("rdata %h, expected %h", resp_rdata, exp_word));
                    assert (line_writes - writes_at_accept == exp_writes &&
                            line_reads - reads_at_accept == (exp_resident ? 0 : 1))
                        else flag_mismatch("wrong number of memory line transfers");
                    in_flight = 1'b0;
                    ops_done++;
                end
            end
            if (req_valid && req_ready) begin
                set              = int'(req_addr[7:5]);
                exp_resident     = res_valid[set] && res_line[set] == req_addr[10:5];
                exp_writes       = (!exp_resident && res_valid[set] && res_dirty[set]) ? 1 : 0;
                victim_addr      = {21'd0, res_line[set], 5'd0}; // old line goes back here
                fill_addr        = {21'd0, req_addr[10:5], 5'd0};
                exp_word         = apply_access(int'(req_addr[10:2]), req_write, req_wdata,
                                                req_mask);
                res_dirty[set]   = (exp_resident && res_dirty[set]) || req_write;
                res_valid[set]   = 1'b1;
                res_line[set]    = req_addr[10:5];
                accept_cycle     = cycle;
                writes_at_accept = line_writes;
                reads_at_accept  = line_reads;
                in_flight        = 1'b1;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle <= cycle + 1;
        if (u_cache_top.u_props.failures != 0) begin
            $display("a protocol assertion on the cache ports failed");
            abort_run();
        end else if (cycle >= max_cycles) begin
            $display("timeout after %0d cycles, the cache stopped making progress", cycle);
            abort_run();
        end
    end

endmodule

// ==== tests/cache_properties.sv ====
`timescale 1ns/1ps

module cache_properties (
    input logic                    clk,
    input logic                    reset,
    input logic                    req_ready,
    input logic                    resp_valid,
    input logic                    resp_ready,
    input cache_pkg::word_t        resp_rdata,
    input logic                    mem_valid,
    input logic                    mem_ready,
    input logic                    mem_write,
    input cache_pkg::addr_t        mem_addr,
    input cache_pkg::line_t        mem_wdata,
    input logic                    mem_rvalid,
    input cache_pkg::cache_state_t state
);

    int failures = 0;                               // failed assertions, polled by the testbench

    // ----------------------------------------------------------------------
    // handshake stability
    // ----------------------------------------------------------------------

    mem_request_held: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write) && $stable(mem_addr) &&
                                    $stable(mem_wdata))
        else begin
            failures++;
            $error("memory request changed before mem_ready");
        end

    response_held: assert property (@(posedge clk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else begin
            failures++;
            $error("response dropped or changed under back-pressure");
        end

    // ----------------------------------------------------------------------
    // protocol
    // ----------------------------------------------------------------------

    ready_or_response: assert property (@(posedge clk) disable iff (reset)
        !(req_ready && resp_valid))
        else begin
            failures++;
            $error("req_ready and resp_valid high together");
        end

    fill_only_when_waiting: assert property (@(posedge clk) disable iff (reset)
        mem_rvalid |-> state == cache_pkg::FILL_WAIT)
        else begin
            failures++;
            $error("fill data arrived outside FILL_WAIT");
        end

endmodule

bind cache_top cache_properties u_props (
    .clk, .reset, .req_ready, .resp_valid, .resp_ready, .resp_rdata,
    .mem_valid, .mem_ready, .mem_write, .mem_addr, .mem_wdata, .mem_rvalid,
    .state(u_control.state)
);

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
    parameter int s_index = 3                    // 8 sets by default
) (
    input  logic              clk,
    input  logic              reset,
    // processor request
    input  logic              req_valid,
    output logic              req_ready,
    input  cache_pkg::addr_t  req_addr,
    input  logic              req_write,
    input  cache_pkg::word_t  req_wdata,
    input  cache_pkg::mask_t  req_mask,
    // processor response
    output logic              resp_valid,
    input  logic              resp_ready,
    output cache_pkg::word_t  resp_rdata,
    // memory request
    output logic              mem_valid,
    input  logic              mem_ready,
    output logic              mem_write,
    output cache_pkg::addr_t  mem_addr,
    output cache_pkg::line_t  mem_wdata,
    // memory fill
    input  logic              mem_rvalid,
    input  cache_pkg::line_t  mem_rdata
);

    localparam int tag_bits = 32 - cache_pkg::offset_bits - s_index;

    // ----------------------------------------------------------------------
    // controller to array wiring
    // ----------------------------------------------------------------------

    logic [s_index-1:0]    index;                // shared by both arrays
    logic [tag_bits-1:0]   req_tag;
    logic [tag_bits-1:0]   victim_tag;
    logic                  hit;
    logic                  dirty;
    logic                  load_tag;
    logic                  set_valid;
    logic                  set_dirty;
    cache_pkg::word_sel_t  word_sel;
    cache_pkg::word_t      wdata;
    cache_pkg::mask_t      wmask;
    logic                  write_word;
    logic                  load_data;
    cache_pkg::line_t      rd_line;
    cache_pkg::word_t      rd_word;

    cache_control #(.s_index(s_index)) u_control (
        .clk, .reset,
        .req_valid, .req_addr, .req_write, .req_wdata, .req_mask, .req_ready,
        .resp_ready, .resp_valid, .resp_rdata,
        .hit, .dirty, .victim_tag, .rd_line, .rd_word,
        .index, .req_tag, .word_sel, .wdata, .wmask,
        .write_word, .load_tag, .set_valid, .set_dirty, .load_data,
        .mem_ready, .mem_rvalid, .mem_valid, .mem_write, .mem_addr, .mem_wdata
    );

    cache_tag_array #(.s_index(s_index)) u_tags (
        .clk, .reset, .index, .req_tag,
        .load_tag, .set_valid, .set_dirty,
        .hit, .dirty, .victim_tag
    );

    cache_data_array #(.s_index(s_index)) u_data (
        .clk, .index, .word_sel, .write_word, .wdata, .wmask,
        .load_data, .fill_line(mem_rdata), // fill comes straight off the memory port
        .rd_line, .rd_word
    );

endmodule

// ==== src/cache_control.sv ====
`timescale 1ns/1ps

module cache_control #(
    parameter int s_index = 3
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          req_valid,
    input  cache_pkg::addr_t                              req_addr,
    input  logic                                          req_write,
    input  cache_pkg::word_t                              req_wdata,
    input  cache_pkg::mask_t                              req_mask,
    input  logic                                          resp_ready,
    input  logic                                          hit,
    input  logic                                          dirty,
    input  logic [32-cache_pkg::offset_bits-s_index-1:0]  victim_tag,
    input  cache_pkg::line_t                              rd_line,
    input  cache_pkg::word_t                              rd_word,
    input  logic                                          mem_ready,
    input  logic                                          mem_rvalid,
    output logic                                          req_ready,
    output logic                                          resp_valid,
    output cache_pkg::word_t                              resp_rdata,
    output logic [s_index-1:0]                            index,
    output logic [32-cache_pkg::offset_bits-s_index-1:0]  req_tag,
    output cache_pkg::word_sel_t                          word_sel,
    output cache_pkg::word_t                              wdata,
    output cache_pkg::mask_t                              wmask,
    output logic                                          write_word,
    output logic                                          load_tag,
    output logic                                          set_valid,
    output logic                                          set_dirty,
    output logic                                          load_data,
    output logic                                          mem_valid,
    output logic                                          mem_write,
    output cache_pkg::addr_t                              mem_addr,
    output cache_pkg::line_t                              mem_wdata
);

    localparam int offset_bits = cache_pkg::offset_bits;
    localparam int tag_bits    = 32 - offset_bits - s_index;

    cache_pkg::cache_state_t state, next_state;
    cache_pkg::addr_t        addr_q;              // address of the request in flight
    logic                    write_q;             // request is a store
    cache_pkg::word_t        wdata_q;
    cache_pkg::mask_t        mask_q;
    cache_pkg::word_t        merged_word;         // stored word with the write bytes laid over it
    logic                    accept;

    assign accept = req_ready && req_valid;       // request handshake

    // ----------------------------------------------------------------------
    // request register and what the arrays see
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_addr;                  // held until the response completes
            write_q <= req_write;
            wdata_q <= req_wdata;
            mask_q  <= req_mask;
        end
    end

    assign index    = addr_q[offset_bits +: s_index];   // both arrays look at the same set
    assign req_tag  = addr_q[31 -: tag_bits];
    assign word_sel = addr_q[offset_bits-1:2];
    assign wdata    = wdata_q;
    assign wmask    = mask_q;

    always_comb begin
        for (int b = 0; b < $bits(cache_pkg::mask_t); b++) begin
            merged_word[b*8 +: 8] = mask_q[b] ? wdata_q[b*8 +: 8] : rd_word[b*8 +: 8];
        end
    end

    assign resp_rdata = write_q ? merged_word : rd_word; // a write answers with the new word
    assign mem_wdata  = rd_line;                         // victim line for the write-back

    // ----------------------------------------------------------------------
    // state machine
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;                              // action defaults, every cycle
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        write_word = 1'b0;
        set_dirty  = 1'b0;
        load_tag   = 1'b0;
        set_valid  = 1'b0;
        load_data  = 1'b0;
        mem_valid  = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = {req_tag, index, {offset_bits{1'b0}}}; // fill address unless storing
        unique case (state)
            cache_pkg::IDLE: begin
                req_ready = !reset;                      // the only state that takes requests once reset is released
                if (req_valid) next_state = cache_pkg::HIT;
            end
            cache_pkg::HIT: begin
                if (hit) begin
                    resp_valid = 1'b1;                   // held until the processor takes it
                    if (resp_ready) begin
                        write_word = write_q;            // store lands on the handshake edge
                        set_dirty  = write_q;
                        next_state = cache_pkg::IDLE;
                    end
                end else if (dirty) begin
                    next_state = cache_pkg::STORE;       // victim must go back first
                end else begin
                    next_state = cache_pkg::LOAD;        // clean victim is simply dropped
                end
            end
            cache_pkg::STORE: begin
                mem_valid = 1'b1;
                mem_write = 1'b1;
                mem_addr  = {victim_tag, index, {offset_bits{1'b0}}}; // where the victim came from
                if (mem_ready) next_state = cache_pkg::LOAD;
            end
            cache_pkg::LOAD: begin
                mem_valid = 1'b1;                        // line read, address is the request's line
                if (mem_ready) next_state = cache_pkg::FILL_WAIT;
            end
            cache_pkg::FILL_WAIT: begin
                if (mem_rvalid) begin
                    load_tag   = 1'b1;                   // tag, valid and data all land together
                    set_valid  = 1'b1;
                    load_data  = 1'b1;
                    next_state = cache_pkg::HIT;         // retry the lookup, it hits now
                end
            end
            default: next_state = cache_pkg::IDLE;
        endcase
    end

endmodule

// ==== src/cache_data_array.sv ====
`timescale 1ns/1ps

module cache_data_array #(
    parameter int s_index = 3
) (
    input  logic                  clk,
    input  logic [s_index-1:0]    index,       // set under access
    input  cache_pkg::word_sel_t  word_sel,    // word inside the line
    input  logic                  write_word,  // merge wdata into the selected word
    input  cache_pkg::word_t      wdata,       // processor write data
    input  cache_pkg::mask_t      wmask,       // bytes of wdata that count
    input  logic                  load_data,   // replace the whole line
    input  cache_pkg::line_t      fill_line,   // line returned by memory
    output cache_pkg::line_t      rd_line,     // whole line, used for write-back
    output cache_pkg::word_t      rd_word      // selected word, used for responses
);

    localparam int num_sets   = 2 ** s_index;
    localparam int word_bits  = $bits(cache_pkg::word_t);
    localparam int mask_bits  = $bits(cache_pkg::mask_t);

    cache_pkg::line_t lines [num_sets];          // line storage, one per set

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------

    assign rd_line = lines[index];                         // combinational read of the set
    assign rd_word = rd_line[word_sel*word_bits +: word_bits]; // pick the addressed word

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (load_data) begin
            lines[index] <= fill_line;                     // fill overwrites everything
        end else if (write_word) begin
            for (int b = 0; b < mask_bits; b++) begin
                if (wmask[b]) begin
                    // only the enabled bytes of the selected word are touched
                    lines[index][word_sel*word_bits + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== src/cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array #(
    parameter int s_index = 3
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [s_index-1:0]                             index,      // set under lookup
    input  logic [32-cache_pkg::offset_bits-s_index-1:0]   req_tag,    // tag of the request
    input  logic                                           load_tag,   // fill writes the tag
    input  logic                                           set_valid,  // fill marks the set valid
    input  logic                                           set_dirty,  // write hit marks it dirty
    output logic                                           hit,
    output logic                                           dirty,
    output logic [32-cache_pkg::offset_bits-s_index-1:0]   victim_tag
);

    localparam int tag_bits = 32 - cache_pkg::offset_bits - s_index; // what is left of the address
    localparam int num_sets = 2 ** s_index;

    logic [tag_bits-1:0] tags [num_sets];                // stored tag per set
    logic [num_sets-1:0] valid_bits;                     // line present
    logic [num_sets-1:0] dirty_bits;                     // line differs from memory

    // ----------------------------------------------------------------------
    // lookup side
    // ----------------------------------------------------------------------

    assign victim_tag = tags[index];                     // tag of whatever sits in the set now
    assign dirty      = dirty_bits[index];               // tells the controller a write-back is due
    assign hit        = valid_bits[index] && (tags[index] == req_tag); // valid and same tag

    // ----------------------------------------------------------------------
    // update side
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (load_tag) begin
            tags[index] <= req_tag;                      // new owner of the set after a fill
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;                            // cache starts empty
            dirty_bits <= '0;                            // and with nothing to write back
        end else begin
            if (set_valid) begin
                valid_bits[index] <= 1'b1;               // freshly filled line is present
                dirty_bits[index] <= 1'b0;               // and matches memory again
            end
            if (set_dirty) begin
                dirty_bits[index] <= 1'b1;               // a write hit leaves it modified
            end
        end
    end

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

    // ----------------------------------------------------------------------
    // line geometry
    // ----------------------------------------------------------------------

    localparam int offset_bits = 5;                  // 32 bytes per line
    localparam int addr_bits   = 32;                 // byte address on both ports
    localparam int word_bits   = 32;                 // one processor word
    localparam int mask_bits   = word_bits / 8;      // one enable per byte of a word
    localparam int line_bits   = 8 * (2 ** offset_bits); // 256 bits move per line transfer
    localparam int sel_bits    = offset_bits - 2;    // word position inside a line

    // ----------------------------------------------------------------------
    // vector types
    // ----------------------------------------------------------------------

    typedef logic [addr_bits-1:0] addr_t;            // processor or memory byte address
    typedef logic [word_bits-1:0] word_t;            // processor data word
    typedef logic [mask_bits-1:0] mask_t;            // byte enables of one word
    typedef logic [line_bits-1:0] line_t;            // one whole cache line
    typedef logic [sel_bits-1:0]  word_sel_t;        // address bits 4 down to 2

    // ----------------------------------------------------------------------
    // controller states
    // ----------------------------------------------------------------------

    // the miss path always runs STORE (only when dirty), then LOAD, then FILL_WAIT
    // and lands back in HIT, where the refilled line now matches
    typedef enum logic [2:0] {
        IDLE      = 3'd0,                            // waiting for a processor request
        HIT       = 3'd1,                            // lookup, serve the hit or start a miss
        STORE     = 3'd2,                            // write the dirty victim back to memory
        LOAD      = 3'd3,                            // issue the line read for the fill
        FILL_WAIT = 3'd4                             // wait for the fill data strobe
    } cache_state_t;

endpackage
